// ==== src/fetch_cfg.svh ====
// fetch front end constants
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// instruction and address widths
`define XLEN        32
`define ADDR_W      18

// branch history table, 16 counters
`define BHT_IDX_W   4

// instruction cache, 8 lines of one word
`define IC_IDX_W    3

// first fetch address after reset
`define RESET_PC    32'h0000_0000

// opcodes seen by the next-pc predictor
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

`endif

// ==== src/fetch_pkg.sv ====
// fetch front end types
`include "fetch_cfg.svh"

package fetch_pkg;

    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [`XLEN-1:0] word_t;

    // 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] ctr_t;

    typedef logic [`BHT_IDX_W-1:0]            bht_idx_t;
    typedef logic [`IC_IDX_W-1:0]             ic_idx_t;
    typedef logic [`ADDR_W-`IC_IDX_W-3:0]     ic_tag_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, seen as raw bits, B-type or J-type
    typedef union packed {
        word_t  raw;
        b_fmt_t b;
        j_fmt_t j;
    } inst_t;

endpackage

// ==== src/bht.sv ====
// branch history table
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module bht import fetch_pkg::*; (
    input  logic     clk_in,
    input  logic     arst_n,
    input  logic     rdy_in,
    input  bht_idx_t rd_idx,
    output ctr_t     rd_ctr,
    input  logic     upd_valid,
    input  bht_idx_t upd_idx,
    input  logic     upd_taken
);

    localparam int DEPTH = 1 << `BHT_IDX_W;

    ctr_t ctr_q [DEPTH];
    ctr_t upd_ctr;

    // prediction read, sees an update from the cycle after it lands
    assign rd_ctr  = ctr_q[rd_idx];
    assign upd_ctr = ctr_q[upd_idx];

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            // weakly not taken
            for (int i = 0; i < DEPTH; i++) begin
                ctr_q[i] <= 2'd1;
            end
        end else if (rdy_in && upd_valid) begin
            // saturate at both ends
            if (upd_taken) begin
                if (upd_ctr != 2'd3) begin
                    ctr_q[upd_idx] <= upd_ctr + 2'd1;
                end
            end else begin
                if (upd_ctr != 2'd0) begin
                    ctr_q[upd_idx] <= upd_ctr - 2'd1;
                end
            end
        end
    end

endmodule

// ==== src/icache.sv ====
// direct-mapped instruction cache
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module icache import fetch_pkg::*; (
    input  logic  clk_in,
    input  logic  arst_n,
    input  logic  rdy_in,
    input  addr_t lookup_pc,
    output logic  hit,
    output word_t hit_word,
    input  logic  fill_done,
    input  addr_t fill_pc,
    input  word_t fill_word
);

    localparam int LINES = 1 << `IC_IDX_W;

    logic [LINES-1:0] valid_q;
    ic_tag_t          tag_q  [LINES];
    word_t            data_q [LINES];

    ic_idx_t lk_idx;
    ic_tag_t lk_tag;
    ic_idx_t fl_idx;
    ic_tag_t fl_tag;

    // bits 1:0 are the byte offset in the word
    assign lk_idx = lookup_pc[`IC_IDX_W+1:2];
    assign lk_tag = lookup_pc[`ADDR_W-1:`IC_IDX_W+2];
    assign fl_idx = fill_pc[`IC_IDX_W+1:2];
    assign fl_tag = fill_pc[`ADDR_W-1:`IC_IDX_W+2];

    assign hit      = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign hit_word = data_q[lk_idx];

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (rdy_in && fill_done) begin
            valid_q[fl_idx] <= 1'b1;
        end
    end

    // a fill replaces whatever the line held
    always_ff @(posedge clk_in) begin
        if (rdy_in && fill_done) begin
            tag_q[fl_idx]  <= fl_tag;
            data_q[fl_idx] <= fill_word;
        end
    end

endmodule

// ==== src/mem_ctrl.sv ====
// byte-serial instruction fill
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module mem_ctrl import fetch_pkg::*; (
    input  logic               clk_in,
    input  logic               arst_n,
    input  logic               rdy_in,
    input  logic               fill_start,
    input  addr_t              fill_pc,
    output logic               fill_done,
    output word_t              fill_word,
    output logic [`ADDR_W-1:0] mem_a,
    output logic               mem_rd,
    input  logic [7:0]         mem_din
);

    logic               busy_q;
    logic [2:0]         a_cnt_q;
    logic [1:0]         d_cnt_q;
    logic [`ADDR_W-3:0] base_q;
    logic [23:0]        shift_q;
    logic               byte_in;
    logic [1:0]         a_sel;

    // data on mem_din belongs to byte d_cnt when an address for it went out
    assign byte_in = busy_q && (a_cnt_q > {1'b0, d_cnt_q});

    // while frozen, re-request the byte still owed, so it lands on release
    assign a_sel  = rdy_in ? a_cnt_q[1:0] : d_cnt_q;
    assign mem_a  = {base_q, a_sel};
    assign mem_rd = busy_q && (!rdy_in || !a_cnt_q[2]);

    // last byte goes straight from the bus into the word
    assign fill_done = busy_q && rdy_in && a_cnt_q[2];
    assign fill_word = {mem_din, shift_q};

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            a_cnt_q <= '0;
            d_cnt_q <= '0;
        end else if (rdy_in) begin
            if (!busy_q) begin
                if (fill_start) begin
                    busy_q  <= 1'b1;
                    a_cnt_q <= '0;
                    d_cnt_q <= '0;
                end
            end else if (fill_done) begin
                busy_q <= 1'b0;
            end else begin
                if (!a_cnt_q[2]) begin
                    a_cnt_q <= a_cnt_q + 3'd1;
                end
                if (byte_in) begin
                    d_cnt_q <= d_cnt_q + 2'd1;
                end
            end
        end
    end

    // lowest byte first, shifted down as the next one arrives
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (!busy_q && fill_start) begin
                base_q <= fill_pc[`ADDR_W-1:2];
            end
            if (byte_in) begin
                shift_q <= {mem_din, shift_q[23:8]};
            end
        end
    end

endmodule

// ==== src/fetch_ctrl.sv ====
// fetch sequencing and next-pc prediction
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_ctrl import fetch_pkg::*; (
    input  logic     clk_in,
    input  logic     arst_n,
    input  logic     rdy_in,
    input  logic     flush_valid,
    input  addr_t    flush_pc,
    output addr_t    ic_pc,
    input  logic     ic_hit,
    input  word_t    ic_word,
    output logic     fill_start,
    input  logic     fill_done,
    input  word_t    fill_word,
    output bht_idx_t bht_idx,
    input  ctr_t     bht_ctr,
    output logic     inst_req,
    output addr_t    inst_pc,
    output word_t    inst_word,
    output logic     inst_pred_taken,
    input  logic     inst_ack
);

    typedef enum logic [1:0] {
        S_LOOK,
        S_FILL,
        S_OFFER,
        S_REL
    } state_e;

    state_e state_q;
    addr_t  pc_q;
    addr_t  redir_pc_q;
    logic   redir_q;
    inst_t  word_q;
    logic   pred_q;
    inst_t  cap_word;
    logic   cap_pred;
    logic   capture;
    addr_t  j_imm;
    addr_t  b_imm;
    addr_t  next_pc;

    // lookup and fill both use the current pc
    assign ic_pc   = pc_q;
    assign bht_idx = pc_q[`BHT_IDX_W+1:2];

    assign fill_start = (state_q == S_LOOK) && !ic_hit && !flush_valid;

    assign cap_word = inst_t'((state_q == S_FILL) ? fill_word : ic_word);
    assign cap_pred = (cap_word.b.opcode == `OPC_BRANCH) && bht_ctr[1];
    assign capture  = ((state_q == S_LOOK) && ic_hit) || ((state_q == S_FILL) && fill_done);

    assign j_imm = {{11{word_q.j.imm20}}, word_q.j.imm20, word_q.j.imm19_12,
                    word_q.j.imm11, word_q.j.imm10_1, 1'b0};
    assign b_imm = {{19{word_q.b.imm12}}, word_q.b.imm12, word_q.b.imm11,
                    word_q.b.imm10_5, word_q.b.imm4_1, 1'b0};

    always_comb begin
        if (word_q.j.opcode == `OPC_JAL) begin
            next_pc = pc_q + j_imm;
        end else if (pred_q) begin
            next_pc = pc_q + b_imm;
        end else begin
            next_pc = pc_q + 32'd4;
        end
    end

    assign inst_req        = (state_q == S_OFFER);
    assign inst_pc         = pc_q;
    assign inst_word       = word_q.raw;
    assign inst_pred_taken = pred_q;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_LOOK;
            pc_q    <= `RESET_PC;
            redir_q <= 1'b0;
        end else if (rdy_in) begin
            case (state_q)
                S_LOOK: begin
                    if (flush_valid) begin
                        pc_q <= flush_pc;
                    end else if (ic_hit) begin
                        state_q <= S_OFFER;
                    end else begin
                        state_q <= S_FILL;
                    end
                end
                S_FILL: begin
                    // the line still gets written, only the word is dropped
                    if (fill_done) begin
                        redir_q <= 1'b0;
                        if (flush_valid || redir_q) begin
                            pc_q    <= flush_valid ? flush_pc : redir_pc_q;
                            state_q <= S_LOOK;
                        end else begin
                            state_q <= S_OFFER;
                        end
                    end else if (flush_valid) begin
                        redir_q <= 1'b1;
                    end
                end
                S_OFFER: begin
                    if (inst_ack) begin
                        state_q <= S_REL;
                    end
                end
                default: begin
                    // advance only once the consumer has let go of ack
                    if (!inst_ack) begin
                        pc_q    <= flush_valid ? flush_pc : next_pc;
                        state_q <= S_LOOK;
                    end
                end
            endcase
        end
    end

    // word and prediction held steady for the whole handshake
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (flush_valid) begin
                redir_pc_q <= flush_pc;
            end
            if (capture) begin
                word_q <= cap_word;
                pred_q <= cap_pred;
            end
        end
    end

endmodule

// ==== src/fetch_top.sv ====
// instruction fetch front end
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_top import fetch_pkg::*; (
    input  logic               clk_in,
    input  logic               arst_n,
    input  logic               rdy_in,
    output logic [`ADDR_W-1:0] mem_a,
    output logic               mem_rd,
    input  logic [7:0]         mem_din,
    output logic               inst_req,
    output addr_t              inst_pc,
    output word_t              inst_word,
    output logic               inst_pred_taken,
    input  logic               inst_ack,
    input  logic               flush_valid,
    input  addr_t              flush_pc,
    input  logic               resolve_valid,
    input  addr_t              resolve_pc,
    input  logic               resolve_taken
);

    addr_t    ic_pc;
    logic     ic_hit;
    word_t    ic_word;
    logic     fill_start;
    logic     fill_done;
    word_t    fill_word;
    bht_idx_t bht_idx;
    ctr_t     bht_ctr;
    bht_idx_t resolve_idx;

    // same pc bits the fetch side uses for its read index
    assign resolve_idx = resolve_pc[`BHT_IDX_W+1:2];

    bht u_bht (
        .clk_in    ( clk_in        ),
        .arst_n    ( arst_n        ),
        .rdy_in    ( rdy_in        ),
        .rd_idx    ( bht_idx       ),
        .rd_ctr    ( bht_ctr       ),
        .upd_valid ( resolve_valid ),
        .upd_idx   ( resolve_idx   ),
        .upd_taken ( resolve_taken )
    );

    icache u_icache (
        .clk_in    ( clk_in    ),
        .arst_n    ( arst_n    ),
        .rdy_in    ( rdy_in    ),
        .lookup_pc ( ic_pc     ),
        .hit       ( ic_hit    ),
        .hit_word  ( ic_word   ),
        .fill_done ( fill_done ),
        .fill_pc   ( ic_pc     ),
        .fill_word ( fill_word )
    );

    mem_ctrl u_mem_ctrl (
        .clk_in     ( clk_in     ),
        .arst_n     ( arst_n     ),
        .rdy_in     ( rdy_in     ),
        .fill_start ( fill_start ),
        .fill_pc    ( ic_pc      ),
        .fill_done  ( fill_done  ),
        .fill_word  ( fill_word  ),
        .mem_a      ( mem_a      ),
        .mem_rd     ( mem_rd     ),
        .mem_din    ( mem_din    )
    );

    fetch_ctrl u_fetch_ctrl (
        .clk_in          ( clk_in          ),
        .arst_n          ( arst_n          ),
        .rdy_in          ( rdy_in          ),
        .flush_valid     ( flush_valid     ),
        .flush_pc        ( flush_pc        ),
        .ic_pc           ( ic_pc           ),
        .ic_hit          ( ic_hit          ),
        .ic_word         ( ic_word         ),
        .fill_start      ( fill_start      ),
        .fill_done       ( fill_done       ),
        .fill_word       ( fill_word       ),
        .bht_idx         ( bht_idx         ),
        .bht_ctr         ( bht_ctr         ),
        .inst_req        ( inst_req        ),
        .inst_pc         ( inst_pc         ),
        .inst_word       ( inst_word       ),
        .inst_pred_taken ( inst_pred_taken ),
        .inst_ack        ( inst_ack        )
    );

endmodule

// ==== dv/tb_fetch_top.sv ====
// fetch front end testbench
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module tb_fetch_top import fetch_pkg::*; ();

    localparam int TIMEOUT   = 200;
    localparam int MEM_BYTES = 1 << `ADDR_W;

    // flush mode 0 is none, 1 lands before the lookup, 2 lands during the fill
    typedef struct {
        int    flush_mode;
        addr_t flush_to;
        int    n_resolve;
        addr_t resolve_at;
        logic  resolve_dir;
        int    rdy_drop;
        addr_t exp_pc;
        word_t exp_word;
        logic  exp_pred;
        logic  exp_hit;
    } row_t;

    logic               clk_in;
    logic               arst_n;
    logic               rdy_in;
    logic [`ADDR_W-1:0] mem_a;
    logic               mem_rd;
    logic [7:0]         mem_din;
    logic               inst_req;
    addr_t              inst_pc;
    word_t              inst_word;
    logic               inst_pred_taken;
    logic               inst_ack;
    logic               flush_valid;
    addr_t              flush_pc;
    logic               resolve_valid;
    addr_t              resolve_pc;
    logic               resolve_taken;

    logic [7:0]  mem [MEM_BYTES];
    int          read_count;
    logic [31:0] lfsr;
    row_t        rows [$];

    fetch_top u_fetch_top (
        .clk_in          ( clk_in          ),
        .arst_n          ( arst_n          ),
        .rdy_in          ( rdy_in          ),
        .mem_a           ( mem_a           ),
        .mem_rd          ( mem_rd          ),
        .mem_din         ( mem_din         ),
        .inst_req        ( inst_req        ),
        .inst_pc         ( inst_pc         ),
        .inst_word       ( inst_word       ),
        .inst_pred_taken ( inst_pred_taken ),
        .inst_ack        ( inst_ack        ),
        .flush_valid     ( flush_valid     ),
        .flush_pc        ( flush_pc        ),
        .resolve_valid   ( resolve_valid   ),
        .resolve_pc      ( resolve_pc      ),
        .resolve_taken   ( resolve_taken   )
    );

    always #50 clk_in = ~clk_in;

    // byte memory answering one cycle after the address
    always begin : mem_model
        logic               rd_seen;
        logic [`ADDR_W-1:0] a_seen;
        @(negedge clk_in);
        rd_seen = mem_rd;
        a_seen  = mem_a;
        @(posedge clk_in);
        #10;
        if (rd_seen) begin
            mem_din    = mem[a_seen];
            read_count = read_count + 1;
        end
    end

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic word_t image_word(input addr_t a);
        logic [`ADDR_W-1:0] b;
        b = a[`ADDR_W-1:0];
        return {mem[b + 3], mem[b + 2], mem[b + 1], mem[b]};
    endfunction

    task automatic put_word(input addr_t a, input word_t w);
        for (int i = 0; i < 4; i++) begin
            mem[a[`ADDR_W-1:0] + i] = w[8*i +: 8];
        end
    endtask

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pc(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("** Error at %0t ns: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp);
        if (got.raw !== exp.raw) begin
            fail_stop($sformatf("** Error at %0t ns: inst_word is %h (opcode %b), expected %h",
                                $time, got.raw, got.b.opcode, exp.raw));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("** Error at %0t ns: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk_in);
        #10;
    endtask

    task automatic wait_req(input logic level);
        int n;
        n = 0;
        @(negedge clk_in);
        while (inst_req !== level) begin
            if (n == TIMEOUT) begin
                fail_stop($sformatf("timeout while waiting for inst_req to go %s",
                                    level ? "high" : "low"));
            end else begin
                n++;
                @(negedge clk_in);
            end
        end
    endtask

    task automatic wait_mem_rd();
        int n;
        n = 0;
        @(negedge clk_in);
        while (mem_rd !== 1'b1) begin
            if (n == TIMEOUT) begin
                fail_stop("timeout while waiting for the fill to start reading memory");
            end else begin
                n++;
                @(negedge clk_in);
            end
        end
    endtask

    task automatic load_image();
        inst_t              w;
        logic [`ADDR_W-1:0] a;
        // background pattern over the whole address
        for (int i = 0; i < MEM_BYTES; i++) begin
            a      = `ADDR_W'(i);
            mem[i] = a[7:0] ^ a[15:8] ^ {6'b0, a[17:16]} ^ 8'h5a;
        end
        put_word(32'h00, 32'h0010_0093);
        put_word(32'h04, 32'h0020_0113);
        put_word(32'h08, 32'h0030_0193);
        // jal x0, +8 over the word at 0x10
        w.raw       = '0;
        w.j.opcode  = `OPC_JAL;
        w.j.imm10_1 = 10'd4;
        put_word(32'h0c, w.raw);
        put_word(32'h14, 32'h0040_0213);
        // beq x1, x2, -4 back to 0x14
        w.raw       = '0;
        w.b.opcode  = `OPC_BRANCH;
        w.b.rs1     = 5'd1;
        w.b.rs2     = 5'd2;
        w.b.imm12   = 1'b1;
        w.b.imm11   = 1'b1;
        w.b.imm10_5 = 6'h3f;
        w.b.imm4_1  = 4'he;
        put_word(32'h18, w.raw);
        put_word(32'h1c, 32'h0050_0293);
    endtask

    task automatic add_row(input int fl, input addr_t fl_pc, input int nres,
                           input addr_t res_pc, input logic res_dir, input int drop,
                           input addr_t pc, input logic pred, input logic hit);
        row_t r;
        r.flush_mode  = fl;
        r.flush_to    = fl_pc;
        r.n_resolve   = nres;
        r.resolve_at  = res_pc;
        r.resolve_dir = res_dir;
        r.rdy_drop    = drop;
        r.exp_pc      = pc;
        r.exp_word    = image_word(pc);
        r.exp_pred    = pred;
        r.exp_hit     = hit;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // flush mode, flush pc, resolves, resolve pc, taken, rdy drop, pc, pred, hit
        add_row(0, 32'h0,       0, 32'h0,  0, 0, `RESET_PC,  0, 0);
        add_row(0, 32'h0,       0, 32'h0,  0, 0, 32'h04,     0, 0);
        add_row(0, 32'h0,       0, 32'h0,  0, 0, 32'h08,     0, 0);
        add_row(0, 32'h0,       0, 32'h0,  0, 0, 32'h0c,     0, 0);
        add_row(0, 32'h0,       0, 32'h0,  0, 0, 32'h14,     0, 0);
        add_row(0, 32'h0,       0, 32'h0,  0, 0, 32'h18,     0, 0);
        // counter for 0x18 goes 1 to 3 during this fill
        add_row(0, 32'h0,       2, 32'h18, 1, 0, 32'h1c,     0, 0);
        add_row(1, 32'h18,      0, 32'h0,  0, 0, 32'h18,     1, 1);
        add_row(0, 32'h0,       0, 32'h0,  0, 0, 32'h14,     0, 1);
        add_row(0, 32'h0,       0, 32'h0,  0, 0, 32'h18,     1, 1);
        add_row(1, 32'h2a5c0,   0, 32'h0,  0, 0, 32'h2a5c0,  0, 0);
        // flush lands while 0x2a5c4 is being filled
        add_row(2, 32'h0c,      0, 32'h0,  0, 0, 32'h0c,     0, 0);
        add_row(0, 32'h0,       0, 32'h0,  0, 0, 32'h14,     0, 1);
        // the discarded fill still left its line behind
        add_row(1, 32'h2a5c4,   0, 32'h0,  0, 0, 32'h2a5c4,  0, 1);
        add_row(1, 32'h1230,    0, 32'h0,  0, 6, 32'h1230,   0, 0);
    endtask

    task automatic run_row(input row_t r);
        int                 reads_before;
        int                 ack_delay;
        logic [`ADDR_W-1:0] held_a;
        reads_before = read_count;
        if (r.flush_mode == 2) begin
            // let the fill get onto the bus first
            wait_mem_rd();
        end
        if (r.flush_mode != 0) begin
            step_cycle();
            flush_valid = 1'b1;
            flush_pc    = r.flush_to;
            step_cycle();
            flush_valid = 1'b0;
        end
        for (int i = 0; i < r.n_resolve; i++) begin
            step_cycle();
            resolve_valid = 1'b1;
            resolve_pc    = r.resolve_at;
            resolve_taken = r.resolve_dir;
            step_cycle();
            resolve_valid = 1'b0;
        end
        if (r.rdy_drop > 0) begin
            // freeze two bytes into the fill
            wait_mem_rd();
            step_cycle();
            step_cycle();
            rdy_in = 1'b0;
            @(negedge clk_in);
            held_a = mem_a;
            for (int i = 0; i < r.rdy_drop; i++) begin
                @(negedge clk_in);
                check_flag(inst_req, 1'b0, "inst_req while frozen");
                check_pc(addr_t'(mem_a), addr_t'(held_a), "mem_a while frozen");
            end
            step_cycle();
            rdy_in = 1'b1;
        end
        wait_req(1'b1);
        check_pc(inst_pc, r.exp_pc, "inst_pc");
        check_inst(inst_word, r.exp_word);
        check_flag(inst_pred_taken, r.exp_pred, "inst_pred_taken");
        if (r.exp_hit) begin
            check_flag(read_count != reads_before, 1'b0, "memory read on a cache hit");
        end else if (r.rdy_drop == 0) begin
            check_flag(read_count == reads_before + 4, 1'b1, "four byte reads for the fill");
        end
        draw_bits(2, ack_delay);
        repeat (ack_delay) step_cycle();
        step_cycle();
        inst_ack = 1'b1;
        wait_req(1'b0);
        step_cycle();
        inst_ack = 1'b0;
    endtask

    initial begin
        clk_in        = 1'b0;
        arst_n        = 1'b0;
        rdy_in        = 1'b1;
        mem_din       = 8'h00;
        inst_ack      = 1'b0;
        flush_valid   = 1'b0;
        flush_pc      = '0;
        resolve_valid = 1'b0;
        resolve_pc    = '0;
        resolve_taken = 1'b0;
        read_count    = 0;
        lfsr          = 32'hd190;
        load_image();
        build_table();
        repeat (4) @(posedge clk_in);
        #10;
        arst_n = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/fetch_pkg.sv
src/bht.sv
src/icache.sv
src/mem_ctrl.sv
src/fetch_ctrl.sv
src/fetch_top.sv
dv/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  - include_dirs:
      - src
    files:
      - src/fetch_pkg.sv
      - src/bht.sv
      - src/icache.sv
      - src/mem_ctrl.sv
      - src/fetch_ctrl.sv
      - src/fetch_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_fetch_top.sv
